//--- hdl/boot_pkg.sv
// shared widths, types and boot command fields
// code and data RAM sizes are fixed here, both clear in 2^CODE_SIZE cycles
package boot_pkg;

  // ====================================================================
  // sizes
  // ====================================================================
  localparam int CODE_SIZE = 10;           // log2 of code words
  localparam int DATA_SIZE = 10;           // log2 of data cells
  localparam int WIDTH     = 18;           // data word width

  typedef logic [7:0]           flash_byte_t;
  typedef logic [15:0]          code_word_t;
  typedef logic [WIDTH-1:0]     data_word_t;  // also the packing register
  typedef logic [15:0]          dest_t;
  typedef logic [15:0]          run_len_t;
  typedef logic [CODE_SIZE-1:0] code_addr_t;
  typedef logic [DATA_SIZE-1:0] data_addr_t;
  typedef logic [2:0]           sink_t;

  // ====================================================================
  // command byte fields
  // ====================================================================
  localparam int CMD_END_BIT    = 5;       // 11-prefix, end of boot
  localparam int CMD_PRESET_BIT = 4;       // p_reset value at end
  localparam int CMD_ADDR_SEL   = 1;       // 0 address, 1 length
  localparam int CMD_TWO_BYTE   = 0;       // high byte follows first
  localparam int SINK_MSB       = 4;
  localparam int SINK_LSB       = 2;
  localparam int BYTES_MSB      = 1;       // bytes per word minus one
  localparam int BYTES_LSB      = 0;

  localparam sink_t SINK_CODE = 3'd0;
  localparam sink_t SINK_DATA = 3'd1;      // other sinks write nothing

  typedef enum logic [2:0] {
    ST_CLEAR,                              // power-up RAM clear
    ST_IDLE,                               // expecting a command byte
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_LEN_HI,
    ST_LEN_LO,
    ST_DATA,                               // packing words
    ST_DONE                                // boot finished, flash ignored
  } boot_state_t;

endpackage

//--- hdl/boot_wr_if.sv
// boot-side write port into the RAMs, one write per cycle with an enable high
// dest is the full 16-bit boot address, the arbiter keeps the low bits
interface boot_wr_if;

  logic                 code_we;           // write word[15:0] to code RAM
  logic                 data_we;           // write word to data RAM
  boot_pkg::dest_t      dest;
  boot_pkg::data_word_t word;

  modport src (
    output code_we,
    output data_we,
    output dest,
    output word
  );

  modport dst (
    input code_we,
    input data_we,
    input dest,
    input word
  );

endinterface

//--- hdl/spram.sv
// single-port RAM, registered read, output holds while i_re is low
// contents are undefined until written
module spram #(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic [DATA_WIDTH-1:0] i_din,
  input  logic                  i_we,
  input  logic                  i_re,
  output logic [DATA_WIDTH-1:0] o_dout
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (i_we) mem[i_addr] <= i_din;
    if (i_re) o_dout <= mem[i_addr];           // read before write
  end

endmodule

//--- hdl/run_counter.sv
// power-up clear length, word run length and bytes left in the current word
// a run of length N covers N+1 words
module run_counter (
  input  logic                  clk,
  input  logic                  arstn,
  input  logic                  i_load_len_hi,
  input  logic                  i_load_len_lo,
  input  logic                  i_load_bytes,
  input  boot_pkg::flash_byte_t i_byte,
  input  logic                  i_take_byte,
  input  logic                  i_word_written,
  output logic                  o_clearing,
  output logic                  o_word_full,
  output logic                  o_run_last
);

  boot_pkg::code_addr_t clr_cnt;               // clear cycles left minus one
  boot_pkg::run_len_t   run_len;               // words left minus one
  logic [1:0]           bytes;                 // bytes per word minus one
  logic [1:0]           byte_cnt;              // bytes left in word minus one

  assign o_word_full = (byte_cnt == 2'd0);
  assign o_run_last  = (run_len == '0);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_clearing <= 1'b1;
      clr_cnt    <= '1;                        // 2^CODE_SIZE cycles
      run_len    <= '0;
      bytes      <= 2'd0;
      byte_cnt   <= 2'd0;
    end else begin
      if (o_clearing) begin
        if (clr_cnt == '0) o_clearing <= 1'b0;
        else               clr_cnt <= clr_cnt - 1'b1;
      end
      if (i_load_len_hi) run_len[15:8] <= i_byte;
      if (i_load_len_lo) run_len[7:0]  <= i_byte;
      if (i_word_written && !o_run_last) run_len <= run_len - 1'b1;
      if (i_load_bytes) begin
        bytes    <= i_byte[boot_pkg::BYTES_MSB:boot_pkg::BYTES_LSB];
        byte_cnt <= i_byte[boot_pkg::BYTES_MSB:boot_pkg::BYTES_LSB];
      end else if (i_take_byte) begin
        byte_cnt <= o_word_full ? bytes : byte_cnt - 2'd1;  // reload per word
      end
    end
  end

endmodule

//--- hdl/boot_dma.sv
// forms boot writes, one cycle after the commit, then bumps dest
// one-byte address form sets only the low byte, dest is 2^CODE_SIZE after clear
module boot_dma (
  input  logic                  clk,
  input  logic                  arstn,
  input  logic                  i_set_dest_hi,
  input  logic                  i_set_dest_lo,
  input  logic                  i_shift_byte,
  input  boot_pkg::flash_byte_t i_byte,
  input  logic                  i_commit,
  input  boot_pkg::sink_t       i_sink,
  input  logic                  i_clear_write,
  boot_wr_if.src                wr
);

  logic                 writing;               // write in progress this cycle
  boot_pkg::data_word_t pack_base;             // word before the next shift

  assign writing   = wr.code_we || wr.data_we;
  assign pack_base = writing ? '0 : wr.word;   // word clears after its write

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      wr.code_we <= 1'b0;
      wr.data_we <= 1'b0;
      wr.dest    <= '0;
      wr.word    <= '0;                        // clear writes zeros
    end else begin
      // enables last one cycle, clear keeps them high throughout
      wr.code_we <= i_clear_write ||
                    (i_commit && (i_sink == boot_pkg::SINK_CODE));
      wr.data_we <= i_clear_write ||
                    (i_commit && (i_sink == boot_pkg::SINK_DATA));

      if (writing) wr.dest <= wr.dest + 1'b1;  // ignored sinks leave dest
      if (i_set_dest_hi) wr.dest[15:8] <= i_byte;
      if (i_set_dest_lo) wr.dest[7:0]  <= i_byte;

      if (i_shift_byte) begin
        wr.word <= {pack_base[boot_pkg::WIDTH-9:0], i_byte};  // msb first
      end else if (writing) begin
        wr.word <= '0;
      end
    end
  end

endmodule

//--- hdl/mem_arbiter.sv
// boot writes take priority over the processor, which is held meanwhile
// processor data writes under hold are dropped, reads return one cycle later
module mem_arbiter (
  input  logic                 clk,
  boot_wr_if.dst               wr,
  input  boot_pkg::code_addr_t i_code_addr,
  output boot_pkg::code_word_t o_insn,
  input  logic                 i_mem_rd,
  input  logic                 i_mem_wr,
  input  boot_pkg::data_addr_t i_mem_addr,
  input  boot_pkg::data_word_t i_mem_din,
  output boot_pkg::data_word_t o_mem_dout,
  output logic                 o_p_hold
);

  boot_pkg::code_addr_t code_addr;
  boot_pkg::data_addr_t data_addr;
  boot_pkg::data_word_t data_din;
  logic                 data_we;

  assign o_p_hold = wr.code_we || wr.data_we;  // hold exactly while boot writes

  assign code_addr = wr.code_we ? wr.dest[boot_pkg::CODE_SIZE-1:0] : i_code_addr;
  assign data_addr = wr.data_we ? wr.dest[boot_pkg::DATA_SIZE-1:0] : i_mem_addr;
  assign data_din  = wr.data_we ? wr.word : i_mem_din;
  assign data_we   = wr.data_we || (i_mem_wr && !o_p_hold);

  spram #(
    .ADDR_WIDTH (boot_pkg::CODE_SIZE),
    .DATA_WIDTH (16)
  ) u_code_ram (
    .clk    (clk),
    .i_addr (code_addr),
    .i_din  (wr.word[15:0]),                   // low 16 bits of packed word
    .i_we   (wr.code_we),
    .i_re   (!o_p_hold),
    .o_dout (o_insn)
  );

  spram #(
    .ADDR_WIDTH (boot_pkg::DATA_SIZE),
    .DATA_WIDTH (boot_pkg::WIDTH)
  ) u_data_ram (
    .clk    (clk),
    .i_addr (data_addr),
    .i_din  (data_din),
    .i_we   (data_we),
    .i_re   (i_mem_rd && !o_p_hold),
    .o_dout (o_mem_dout)
  );

endmodule

//--- hdl/boot_fsm.sv
// interprets the flash byte stream, one byte per cycle at most
// takes a byte only while i_fl_valid is high, waits otherwise with state held
module boot_fsm (
  input  logic                  clk,
  input  logic                  arstn,
  input  logic                  i_fl_valid,
  input  boot_pkg::flash_byte_t i_fl_byte,
  output logic                  o_fl_rd,
  // counter commands and status
  output logic                  o_load_len_hi,
  output logic                  o_load_len_lo,
  output logic                  o_load_bytes,
  output logic                  o_take_byte,
  output logic                  o_word_written,
  input  logic                  i_clearing,
  input  logic                  i_word_full,
  input  logic                  i_run_last,
  // dma commands
  output logic                  o_set_dest_hi,
  output logic                  o_set_dest_lo,
  output logic                  o_shift_byte,
  output logic                  o_commit,
  output boot_pkg::sink_t       o_sink,
  output logic                  o_clear_write,
  // processor control
  output logic                  o_p_reset,
  output logic                  o_booting
);

  boot_pkg::boot_state_t state;
  logic                  cmd_take;                    // command byte taken
  logic                  data_take;                   // data byte taken

  assign o_fl_rd = i_fl_valid && (state != boot_pkg::ST_CLEAR)
                              && (state != boot_pkg::ST_DONE);
  assign cmd_take  = o_fl_rd && (state == boot_pkg::ST_IDLE);
  assign data_take = o_fl_rd && (state == boot_pkg::ST_DATA);

  // ====================================================================
  // single-cycle commands, all qualified by the take
  // ====================================================================
  assign o_load_len_hi  = o_fl_rd && (state == boot_pkg::ST_LEN_HI);
  assign o_load_len_lo  = o_fl_rd && (state == boot_pkg::ST_LEN_LO);
  assign o_load_bytes   = cmd_take && !i_fl_byte[7];  // 00 or 01 prefix
  assign o_set_dest_hi  = o_fl_rd && (state == boot_pkg::ST_ADDR_HI);
  assign o_set_dest_lo  = o_fl_rd && (state == boot_pkg::ST_ADDR_LO);
  assign o_take_byte    = data_take;
  assign o_shift_byte   = data_take;
  assign o_commit       = data_take && i_word_full;   // last byte of word
  assign o_word_written = o_commit;
  assign o_clear_write  = (state == boot_pkg::ST_CLEAR) && i_clearing;

  // ====================================================================
  // state register
  // ====================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= boot_pkg::ST_CLEAR;
      o_sink    <= boot_pkg::SINK_CODE;
      o_p_reset <= 1'b1;                              // cpu held in reset
      o_booting <= 1'b1;
    end else begin
      case (state)
        boot_pkg::ST_CLEAR:
          if (!i_clearing) state <= boot_pkg::ST_IDLE;
        boot_pkg::ST_IDLE:
          if (cmd_take) begin
            case (i_fl_byte[7:6])
              2'b11:
                if (i_fl_byte[boot_pkg::CMD_END_BIT]) begin
                  state     <= boot_pkg::ST_DONE;
                  o_p_reset <= i_fl_byte[boot_pkg::CMD_PRESET_BIT];
                  o_booting <= 1'b0;
                end else if (i_fl_byte[boot_pkg::CMD_ADDR_SEL]) begin
                  state <= i_fl_byte[boot_pkg::CMD_TWO_BYTE] ?
                           boot_pkg::ST_LEN_HI : boot_pkg::ST_LEN_LO;
                end else begin
                  state <= i_fl_byte[boot_pkg::CMD_TWO_BYTE] ?
                           boot_pkg::ST_ADDR_HI : boot_pkg::ST_ADDR_LO;
                end
              2'b10: state <= boot_pkg::ST_IDLE;      // sclk rate, ignored
              default: begin                          // data mode
                o_sink <= i_fl_byte[boot_pkg::SINK_MSB:boot_pkg::SINK_LSB];
                state  <= boot_pkg::ST_DATA;
              end
            endcase
          end
        boot_pkg::ST_ADDR_HI:
          if (o_fl_rd) state <= boot_pkg::ST_ADDR_LO;
        boot_pkg::ST_ADDR_LO:
          if (o_fl_rd) state <= boot_pkg::ST_IDLE;
        boot_pkg::ST_LEN_HI:
          if (o_fl_rd) state <= boot_pkg::ST_LEN_LO;
        boot_pkg::ST_LEN_LO:
          if (o_fl_rd) state <= boot_pkg::ST_IDLE;
        boot_pkg::ST_DATA:
          if (o_commit && i_run_last) state <= boot_pkg::ST_IDLE; // run done
        default: state <= boot_pkg::ST_DONE;          // done is terminal
      endcase
    end
  end

endmodule

//--- hdl/boot_loader.sv
// flash boot loader with code and data RAM, flash port delivers plain bytes
// processor is held while boot writes own the RAMs, reset released by end cmd
module boot_loader (
  input  logic                   clk,
  input  logic                   arstn,       // async, active low
  // flash byte stream
  input  logic                   i_fl_valid,
  input  boot_pkg::flash_byte_t  i_fl_byte,
  output logic                   o_fl_rd,     // take strobe
  // processor code port
  input  boot_pkg::code_addr_t   i_code_addr,
  output boot_pkg::code_word_t   o_insn,
  // processor data port
  input  logic                   i_mem_rd,
  input  logic                   i_mem_wr,
  input  boot_pkg::data_addr_t   i_mem_addr,
  input  boot_pkg::data_word_t   i_mem_din,
  output boot_pkg::data_word_t   o_mem_dout,
  // processor control
  output logic                   o_p_hold,
  output logic                   o_p_reset,
  output logic                   o_booting
);

  // fsm to counters
  logic load_len_hi, load_len_lo, load_bytes;
  logic take_byte, word_written;
  logic clearing, word_full, run_last;      // counter status

  // fsm to dma
  logic            set_dest_hi, set_dest_lo;
  logic            shift_byte, commit, clear_write;
  boot_pkg::sink_t sink;

  boot_wr_if wr_bus ();

  boot_fsm u_fsm (
    .clk            (clk),
    .arstn          (arstn),
    .i_fl_valid     (i_fl_valid),
    .i_fl_byte      (i_fl_byte),
    .o_fl_rd        (o_fl_rd),
    .o_load_len_hi  (load_len_hi),
    .o_load_len_lo  (load_len_lo),
    .o_load_bytes   (load_bytes),
    .o_take_byte    (take_byte),
    .o_word_written (word_written),
    .i_clearing     (clearing),
    .i_word_full    (word_full),
    .i_run_last     (run_last),
    .o_set_dest_hi  (set_dest_hi),
    .o_set_dest_lo  (set_dest_lo),
    .o_shift_byte   (shift_byte),
    .o_commit       (commit),
    .o_sink         (sink),
    .o_clear_write  (clear_write),
    .o_p_reset      (o_p_reset),
    .o_booting      (o_booting)
  );

  run_counter u_cnt (
    .clk            (clk),
    .arstn          (arstn),
    .i_load_len_hi  (load_len_hi),
    .i_load_len_lo  (load_len_lo),
    .i_load_bytes   (load_bytes),
    .i_byte         (i_fl_byte),
    .i_take_byte    (take_byte),
    .i_word_written (word_written),
    .o_clearing     (clearing),
    .o_word_full    (word_full),
    .o_run_last     (run_last)
  );

  boot_dma u_dma (
    .clk           (clk),
    .arstn         (arstn),
    .i_set_dest_hi (set_dest_hi),
    .i_set_dest_lo (set_dest_lo),
    .i_shift_byte  (shift_byte),
    .i_byte        (i_fl_byte),
    .i_commit      (commit),
    .i_sink        (sink),
    .i_clear_write (clear_write),
    .wr            (wr_bus.src)
  );

  mem_arbiter u_arb (
    .clk         (clk),
    .wr          (wr_bus.dst),
    .i_code_addr (i_code_addr),
    .o_insn      (o_insn),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),
    .i_mem_din   (i_mem_din),
    .o_mem_dout  (o_mem_dout),
    .o_p_hold    (o_p_hold)
  );

endmodule

//--- testbench/boot_loader_props.sv
// flash handshake, hold and booting checks, bound into the top level
// assumes a boot write lands one cycle after its commit
module boot_loader_props (
  input logic                  clk,
  input logic                  arstn,
  input logic                  i_fl_valid,
  input boot_pkg::flash_byte_t i_fl_byte,
  input logic                  i_fl_rd,
  input logic                  i_booting,
  input logic                  i_hold,
  input logic                  i_commit,
  input boot_pkg::sink_t       i_sink
);

  logic end_take;                                  // end command taken
  logic ram_commit;                                // word bound for code or data RAM

  assign end_take   = i_fl_rd && (i_fl_byte[7:6] == 2'b11)
                              && i_fl_byte[boot_pkg::CMD_END_BIT];
  assign ram_commit = i_commit && ((i_sink == boot_pkg::SINK_CODE)
                               || (i_sink == boot_pkg::SINK_DATA));

  // take strobe only with a byte present, and only while booting
  a_rd_needs_valid : assert property (@(posedge clk) disable iff (!arstn)
    i_fl_rd |-> (i_fl_valid && i_booting))
    else $error("o_fl_rd high without a byte or after boot ended");

  // boot ends on the edge after the end command, never otherwise
  a_booting_ends_on_cmd : assert property (@(posedge clk) disable iff (!arstn)
    $fell(i_booting) |-> $past(end_take))
    else $error("o_booting fell without an end command");

  a_hold_after_commit : assert property (@(posedge clk) disable iff (!arstn)
    ram_commit |=> i_hold)
    else $error("o_p_hold low in the write cycle of a committed word");

  a_no_hold_after_boot : assert property (@(posedge clk) disable iff (!arstn)
    !i_booting |-> !i_hold)
    else $error("o_p_hold high after boot ended");

endmodule

bind boot_loader boot_loader_props u_props (
  .clk        (clk),
  .arstn      (arstn),
  .i_fl_valid (i_fl_valid),
  .i_fl_byte  (i_fl_byte),
  .i_fl_rd    (o_fl_rd),
  .i_booting  (o_booting),
  .i_hold     (o_p_hold),
  .i_commit   (commit),
  .i_sink     (sink)
);

//--- testbench/tb_boot_loader.sv
// streams a boot image through the flash port with random gaps, then reads back both RAMs
// assumes code and data RAM are both cleared by the power-up pass
module tb_boot_loader;

  logic                  clk = 1'b0;
  logic                  arstn;
  logic                  i_fl_valid;
  boot_pkg::flash_byte_t i_fl_byte;
  logic                  o_fl_rd;
  boot_pkg::code_addr_t  i_code_addr;
  boot_pkg::code_word_t  o_insn;
  logic                  i_mem_rd;
  logic                  i_mem_wr;
  boot_pkg::data_addr_t  i_mem_addr;
  boot_pkg::data_word_t  i_mem_din;
  boot_pkg::data_word_t  o_mem_dout;
  logic                  o_p_hold;
  logic                  o_p_reset;
  logic                  o_booting;

  boot_pkg::flash_byte_t image [$];                 // boot stream, cmds and payload
  boot_pkg::code_word_t  exp_code [1 << boot_pkg::CODE_SIZE];
  boot_pkg::data_word_t  exp_data [1 << boot_pkg::DATA_SIZE];
  logic                  exp_p_reset;
  integer                seed;
  int                    rd_ptr;                    // next image byte to offer
  int                    wd_cycles;

  boot_loader i_dut (.*);

  always #2 clk = ~clk;

  // ======================================================================
  // flash byte model
  // ======================================================================
  always @(posedge clk) begin
    if (o_fl_rd) rd_ptr <= rd_ptr + 1;              // byte taken on this edge
  end

  always @(negedge clk) begin
    if (rd_ptr < image.size() && ($random(seed) & 3) != 0) begin
      i_fl_valid = 1'b1;
      i_fl_byte  = image[rd_ptr];
    end else begin
      i_fl_valid = 1'b0;                            // gap, junk on the byte lines
      i_fl_byte  = boot_pkg::flash_byte_t'($random(seed));
    end
  end

  task automatic push_payload(input int n);
    repeat (n) image.push_back(boot_pkg::flash_byte_t'($random(seed)));
  endtask

  task automatic build_image();
    image.push_back(8'h95);                         // sclk rate, no effect
    image.push_back(8'hc0);                         // one-byte dest
    image.push_back(8'h40);
    image.push_back(8'hc2);                         // one-byte length, 3 words
    image.push_back(8'h02);
    image.push_back(8'h06);                         // data sink, 3 bytes per word
    push_payload(9);
    image.push_back(8'hc1);                         // two-byte dest 0x0120
    image.push_back(8'h01);
    image.push_back(8'h20);
    image.push_back(8'hc3);                         // two-byte length, 4 words
    image.push_back(8'h00);
    image.push_back(8'h03);
    image.push_back(8'h01);                         // code sink, 2 bytes per word
    push_payload(8);
    image.push_back(8'hbf);
    image.push_back(8'hc2);                         // 2 words into sink 3
    image.push_back(8'h01);
    image.push_back(8'h0d);
    push_payload(4);
    image.push_back(8'h41);                         // 01 prefix, code, single word
    push_payload(2);
    image.push_back(8'he0);                         // end, release p_reset
    image.push_back(8'h01);                         // after the end, never taken
    push_payload(3);
  endtask

  // ======================================================================
  // reference interpreter, fills exp_code and exp_data
  // ======================================================================
  function automatic logic expected_mems();
    boot_pkg::dest_t       dest;
    boot_pkg::run_len_t    len;
    boot_pkg::data_word_t  word;
    boot_pkg::flash_byte_t b;
    logic [15:0]           v;
    int                    i;
    int                    w;
    int                    k;
    dest = boot_pkg::dest_t'(1 << boot_pkg::CODE_SIZE);  // clear runs dest past the top
    len  = '0;
    word = '0;
    i    = 0;
    foreach (exp_code[a]) exp_code[a] = '0;
    foreach (exp_data[a]) exp_data[a] = '0;
    while (i < image.size()) begin
      b = image[i];
      i++;
      if (b[7:6] == 2'b11 && b[boot_pkg::CMD_END_BIT]) begin
        return b[boot_pkg::CMD_PRESET_BIT];
      end else if (b[7:6] == 2'b11) begin
        v = b[boot_pkg::CMD_ADDR_SEL] ? len : dest;  // one-byte form keeps high byte
        if (b[boot_pkg::CMD_TWO_BYTE]) begin
          v[15:8] = image[i];
          i++;
        end
        v[7:0] = image[i];
        i++;
        if (b[boot_pkg::CMD_ADDR_SEL]) len = v;
        else                           dest = v;
      end else if (!b[7]) begin                     // data mode, N+1 words
        for (w = 0; w <= int'(len); w++) begin
          for (k = 0; k <= int'(b[1:0]); k++) begin
            word = (word << 8) | image[i];          // msb first, top bits fall off
            i++;
          end
          if (b[4:2] == 3'd0) exp_code[dest[boot_pkg::CODE_SIZE-1:0]] = word[15:0];
          if (b[4:2] == 3'd1) exp_data[dest[boot_pkg::DATA_SIZE-1:0]] = word;
          if (b[4:2] <= 3'd1) begin                 // other sinks keep dest and word
            dest++;
            word = '0;
          end
        end
        len = '0;                                   // counter ends the run at zero
      end
    end
    return 1'b1;
  endfunction

  // ======================================================================
  // compare tasks
  // ======================================================================
  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_code(input boot_pkg::code_word_t act, input boot_pkg::code_word_t exp,
                            input string what);
    if (act !== exp) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input boot_pkg::data_word_t act, input boot_pkg::data_word_t exp,
                            input string what);
    if (act !== exp) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, act, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("FAILED at %0t: %s, got %b expected %b", $time, what, act, exp);
      abort_run();
    end
  endtask

  initial begin
    @(posedge arstn);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: no result after %0d cycles, boot or readback stalled", wd_cycles);
    abort_run();
  end

  initial begin
    int a;
    seed        = 32'h4f923d8d;
    arstn       = 1'b0;
    i_fl_valid  = 1'b0;
    i_fl_byte   = '0;
    i_code_addr = '0;
    i_mem_rd    = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_addr  = '0;
    i_mem_din   = '0;
    rd_ptr      = 0;
    build_image();
    exp_p_reset = expected_mems();
    wd_cycles   = (1 << boot_pkg::CODE_SIZE) + 8 * image.size()
                + 4 * (1 << boot_pkg::DATA_SIZE) + 16;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstn = 1'b1;
    check_bit(o_booting, 1'b1, "booting after reset");
    check_bit(o_p_reset, 1'b1, "p_reset after reset");
    @(negedge clk);
    check_bit(o_p_hold, 1'b1, "hold during clear");
    while (o_booting) @(negedge clk);
    check_bit(o_p_reset, exp_p_reset, "p_reset after end command");
    check_bit(o_p_hold, 1'b0, "hold after boot");
    for (a = 0; a < (1 << boot_pkg::CODE_SIZE); a++) begin
      i_code_addr = boot_pkg::code_addr_t'(a);
      @(negedge clk);                               // registered read
      check_code(o_insn, exp_code[a], $sformatf("code word at %0d", a));
    end
    i_mem_rd = 1'b1;
    for (a = 0; a < (1 << boot_pkg::DATA_SIZE); a++) begin
      i_mem_addr = boot_pkg::data_addr_t'(a);
      @(negedge clk);
      check_data(o_mem_dout, exp_data[a], $sformatf("data word at %0d", a));
    end
    // processor owns the data RAM once boot is over
    i_mem_rd   = 1'b0;
    i_mem_wr   = 1'b1;
    i_mem_addr = 10'h2a5;
    i_mem_din  = 18'h2b3c5;
    @(negedge clk);
    i_mem_wr = 1'b0;
    i_mem_rd = 1'b1;
    @(negedge clk);
    i_mem_rd = 1'b0;
    check_data(o_mem_dout, 18'h2b3c5, "processor write then read");
    $display("test passed");
    $finish;
  end

endmodule

//--- compile.f
hdl/boot_pkg.sv
hdl/boot_wr_if.sv
hdl/spram.sv
hdl/run_counter.sv
hdl/boot_dma.sv
hdl/mem_arbiter.sv
hdl/boot_fsm.sv
hdl/boot_loader.sv
testbench/boot_loader_props.sv
testbench/tb_boot_loader.sv
